/* common/videoPkg.sv */
package videoPkg;

    // ------------------------------------------------------------------------
    // raster coordinates
    // ------------------------------------------------------------------------

    // wide enough for 640 columns and 480 rows
    typedef logic [9:0] coordT;

    localparam coordT ScreenYMax = 10'd479;

    // ------------------------------------------------------------------------
    // colour types and palette
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // yellow ball
    localparam rgbT BallColor = '{red: 8'hCA, green: 8'hC9, blue: 8'h2E};

    // green platforms
    localparam rgbT PlatformColor = '{red: 8'h66, green: 8'hDD, blue: 8'h11};

    // red cannon
    localparam rgbT CannonColor = '{red: 8'hFF, green: 8'h00, blue: 8'h00};

    // sandy backdrop
    localparam rgbT BackgroundColor = '{red: 8'h98, green: 8'h85, blue: 8'h58};

endpackage

/* common/playfieldPkg.sv */
package playfieldPkg;

    import videoPkg::*;

    // ------------------------------------------------------------------------
    // platform generation
    // ------------------------------------------------------------------------

    localparam int LfsrWidth = 9;

    typedef logic [LfsrWidth-1:0] lfsrT;

    // platform box half extents
    localparam coordT PlatHalfX = 10'd10;
    localparam coordT PlatHalfY = 10'd4;

    // ------------------------------------------------------------------------
    // game objects
    // ------------------------------------------------------------------------

    // square sprite, size is the half width
    typedef struct packed {
        coordT x;
        coordT y;
        coordT size;
    } spriteT;

    // platform centre
    typedef struct packed {
        coordT x;
        coordT y;
    } platformT;

    typedef struct packed {
        logic [7:0] displacement;
        logic       refreshEn;
    } scrollT;

    // ------------------------------------------------------------------------
    // register words and map
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [1:0] pad;
        spriteT     sprite;
    } spriteWordT;

    typedef struct packed {
        logic [22:0] pad;
        scrollT      setting;
    } scrollWordT;

    // one bus word, read as a sprite or a scroll setting by address
    typedef union packed {
        spriteWordT spriteView;
        scrollWordT scrollView;
    } regWordT;

    localparam logic [3:0] BallAddr   = 4'd0;
    localparam logic [3:0] CannonAddr = 4'd4;
    localparam logic [3:0] ScrollAddr = 4'd8;

endpackage

/* logic/apbRegs.sv */
`timescale 1ns/1ps

module apbRegs
    import playfieldPkg::*;
(
    input  logic       loadplat,
    input  logic       rstN,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [3:0] paddr,
    input  regWordT    pwdata,
    output regWordT    prdata,
    output logic       pready,
    output logic       pslverr,
    output spriteT     ballSprite,
    output spriteT     cannonSprite,
    output scrollT     scroll
);

    logic access;
    logic mapped;

    // second cycle of a transfer
    assign access = psel && penable;

    assign mapped = (paddr == BallAddr) || (paddr == CannonAddr) || (paddr == ScrollAddr);

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    // ------------------------------------------------------------------------
    // register writes
    // ------------------------------------------------------------------------

    always_ff @(posedge loadplat or negedge rstN)
    begin
        if (!rstN)
        begin
            ballSprite   <= '0;
            cannonSprite <= '0;
            scroll       <= '0;
        end
        else if (access && pwrite)
        begin
            // unmapped addresses fall through untouched
            case (paddr)
                BallAddr:   ballSprite   <= pwdata.spriteView.sprite;
                CannonAddr: cannonSprite <= pwdata.spriteView.sprite;
                ScrollAddr: scroll       <= pwdata.scrollView.setting;
                default:    ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // read mux, pad bits stay zero
    // ------------------------------------------------------------------------

    always_comb
    begin
        prdata = '0;
        case (paddr)
            BallAddr:   prdata.spriteView.sprite  = ballSprite;
            CannonAddr: prdata.spriteView.sprite  = cannonSprite;
            ScrollAddr: prdata.scrollView.setting = scroll;
            default:    prdata = '0;
        endcase
    end

    // an error is only raised in an access cycle that follows a setup cycle
    assert property (@(posedge loadplat) disable iff (!rstN)
        pslverr |-> penable && $past(psel && !penable));

endmodule

/* playfield/lfsrChain.sv */
`timescale 1ns/1ps

module lfsrChain
    import playfieldPkg::*;
#(
    parameter int unsigned NumPlatforms = 16,
    parameter lfsrT        LfsrSeed     = 9'h1A5
)
(
    input  logic loadplat,
    input  logic rstN,
    output lfsrT lfsrStates [NumPlatforms]
);

    // seed for stage i is the base seed rotated left by i
    function automatic lfsrT rotateSeed(input int unsigned amount);
        lfsrT rotated;
        rotated = LfsrSeed;
        for (int unsigned k = 0; k < amount % LfsrWidth; k++)
        begin
            rotated = {rotated[LfsrWidth-2:0], rotated[LfsrWidth-1]};
        end
        return rotated;
    endfunction

    // taps 9 and 5, maximal length
    function automatic lfsrT stepLfsr(input lfsrT state);
        return {state[LfsrWidth-2:0], state[8] ^ state[4]};
    endfunction

    for (genvar i = 0; i < NumPlatforms; i++)
    begin : gStage
        localparam lfsrT StageSeed = rotateSeed(i);

        always_ff @(posedge loadplat or negedge rstN)
        begin
            if (!rstN)
                lfsrStates[i] <= StageSeed;
            else
                lfsrStates[i] <= stepLfsr(lfsrStates[i]);
        end

        // all-zero would lock the stage up for good
        assert property (@(posedge loadplat) disable iff (!rstN) lfsrStates[i] != '0);
    end

endmodule

/* playfield/platformBank.sv */
`timescale 1ns/1ps

module platformBank
    import videoPkg::*;
    import playfieldPkg::*;
#(
    parameter int unsigned NumPlatforms = 16,
    parameter lfsrT        LfsrSeed     = 9'h1A5,
    parameter int unsigned XOffset      = 100,
    parameter int unsigned RowPitch     = 29
)
(
    input  logic     loadplat,
    input  logic     rstN,
    input  scrollT   scroll,
    output platformT platforms [NumPlatforms],
    output logic     platValid
);

    lfsrT lfsrStates [NumPlatforms];

    lfsrChain #(
        .NumPlatforms(NumPlatforms),
        .LfsrSeed    (LfsrSeed)
    ) uLfsrChain (
        .loadplat  (loadplat),
        .rstN      (rstN),
        .lfsrStates(lfsrStates)
    );

    // positions are loaded from the first edge on
    always_ff @(posedge loadplat or negedge rstN)
    begin
        if (!rstN)
            platValid <= 1'b0;
        else
            platValid <= 1'b1;
    end

    // ------------------------------------------------------------------------
    // one row per platform
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NumPlatforms; i++)
    begin : gPlatform
        localparam coordT RowBase = coordT'(RowPitch * (i + 1));

        always_ff @(posedge loadplat or negedge rstN)
        begin
            if (!rstN)
            begin
                platforms[i] <= '0;
            end
            else
            begin
                platforms[i].x <= coordT'(XOffset) + coordT'(lfsrStates[i]);
                // scrolling shifts every row down by the same amount
                if (scroll.refreshEn)
                    platforms[i].y <= RowBase + coordT'(scroll.displacement);
                else
                    platforms[i].y <= RowBase;
            end
        end

        assert property (@(posedge loadplat) disable iff (!rstN)
            platValid |-> platforms[i].y <= ScreenYMax);
    end

endmodule

/* logic/colorMapper.sv */
`timescale 1ns/1ps

module colorMapper
    import videoPkg::*;
    import playfieldPkg::*;
#(
    parameter int unsigned NumPlatforms = 16
)
(
    input  logic     loadplat,
    input  logic     rstN,
    input  coordT    drawX,
    input  coordT    drawY,
    input  spriteT   ballSprite,
    input  spriteT   cannonSprite,
    input  platformT platforms [NumPlatforms],
    output rgbT      rgb
);

    // ------------------------------------------------------------------------
    // hit tests
    // ------------------------------------------------------------------------

    // inclusive box test on absolute distance with no wrap at the screen edge
    function automatic logic boxHit(
        input coordT px,
        input coordT py,
        input coordT cx,
        input coordT cy,
        input coordT halfX,
        input coordT halfY
    );
        coordT distX;
        coordT distY;
        distX = (px >= cx) ? px - cx : cx - px;
        distY = (py >= cy) ? py - cy : cy - py;
        return (distX <= halfX) && (distY <= halfY);
    endfunction

    logic                    ballOn;
    logic                    cannonOn;
    logic                    platOn;
    logic [NumPlatforms-1:0] platHits;
    rgbT                     nextRgb;

    assign ballOn = boxHit(drawX, drawY, ballSprite.x, ballSprite.y,
                           ballSprite.size, ballSprite.size);

    assign cannonOn = boxHit(drawX, drawY, cannonSprite.x, cannonSprite.y,
                             cannonSprite.size, cannonSprite.size);

    for (genvar i = 0; i < NumPlatforms; i++)
    begin : gPlatHit
        assign platHits[i] = boxHit(drawX, drawY, platforms[i].x, platforms[i].y,
                                    PlatHalfX, PlatHalfY);
    end

    assign platOn = |platHits;

    // ------------------------------------------------------------------------
    // priority and output register
    // ------------------------------------------------------------------------

    // ball over platforms over cannon
    assign nextRgb = ballOn   ? BallColor :
                     platOn   ? PlatformColor :
                     cannonOn ? CannonColor : BackgroundColor;

    always_ff @(posedge loadplat or negedge rstN)
    begin
        if (!rstN)
            rgb <= '0;
        else
            rgb <= nextRgb;
    end

    assert property (@(posedge loadplat) disable iff (!rstN) !$isunknown(rgb));

endmodule

/* logic/playfieldTop.sv */
`timescale 1ns/1ps

module playfieldTop
    import videoPkg::*;
    import playfieldPkg::*;
#(
    parameter int unsigned NumPlatforms = 16,
    parameter lfsrT        LfsrSeed     = 9'h1A5,
    parameter int unsigned XOffset      = 100,
    parameter int unsigned RowPitch     = 29
)
(
    input  logic       loadplat,
    input  logic       rstN,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [3:0] paddr,
    input  regWordT    pwdata,
    output regWordT    prdata,
    output logic       pready,
    output logic       pslverr,
    input  coordT      drawX,
    input  coordT      drawY,
    output rgbT        rgb,
    output platformT   platforms [NumPlatforms],
    output logic       platValid
);

    spriteT ballSprite;
    spriteT cannonSprite;
    scrollT scroll;

    // ------------------------------------------------------------------------
    // bus registers
    // ------------------------------------------------------------------------

    apbRegs uApbRegs (
        .loadplat    (loadplat),
        .rstN        (rstN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .ballSprite  (ballSprite),
        .cannonSprite(cannonSprite),
        .scroll      (scroll)
    );

    // ------------------------------------------------------------------------
    // platforms and pixel colour
    // ------------------------------------------------------------------------

    platformBank #(
        .NumPlatforms(NumPlatforms),
        .LfsrSeed    (LfsrSeed),
        .XOffset     (XOffset),
        .RowPitch    (RowPitch)
    ) uPlatformBank (
        .loadplat (loadplat),
        .rstN     (rstN),
        .scroll   (scroll),
        .platforms(platforms),
        .platValid(platValid)
    );

    colorMapper #(
        .NumPlatforms(NumPlatforms)
    ) uColorMapper (
        .loadplat    (loadplat),
        .rstN        (rstN),
        .drawX       (drawX),
        .drawY       (drawY),
        .ballSprite  (ballSprite),
        .cannonSprite(cannonSprite),
        .platforms   (platforms),
        .rgb         (rgb)
    );

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen
#(
    parameter int HalfPeriod  = 5,
    parameter int ResetCycles = 16
)
(
    output logic loadplat,
    output logic rstN
);

    initial
    begin
        loadplat = 1'b0;
        forever #HalfPeriod loadplat = ~loadplat;
    end

    // release lines up with a falling edge
    initial
    begin
        rstN = 1'b0;
        repeat (ResetCycles) @(negedge loadplat);
        rstN = 1'b1;
    end

endmodule

/* sim/playfieldTb.sv */
`timescale 1ns/1ps

module playfieldTb
    import playfieldPkg::*;
();

    localparam int          NumPlatforms = 16;
    localparam logic [8:0]  LfsrSeed     = 9'h1A5;
    localparam int          XOffset      = 100;
    localparam int          RowPitch     = 29;
    localparam int          HalfX        = 10;
    localparam int          HalfY        = 4;
    localparam logic [23:0] BallRgb      = 24'hCAC92E;
    localparam logic [23:0] PlatRgb      = 24'h66DD11;
    localparam logic [23:0] CannonRgb    = 24'hFF0000;
    localparam logic [23:0] BackRgb      = 24'h988558;
    localparam string       TestFile     = "sim/pixelTests.txt";

    logic        loadplat;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [9:0]  drawX;
    logic [9:0]  drawY;
    logic [23:0] rgb;
    platformT    platforms [NumPlatforms];
    logic        platValid;

    // reference model state
    logic [8:0] lfsrModel [NumPlatforms];
    logic [8:0] prevModel [NumPlatforms];
    spriteT     ballModel;
    spriteT     cannonModel;
    scrollT     scrollModel;
    scrollT     appliedScroll;
    int         edgeCount;

    int     apbErrors   = 0;
    int     platErrors  = 0;
    int     pixelErrors = 0;
    int     otherErrors = 0;
    int     apbChecks   = 0;
    int     platChecks  = 0;
    int     pixelChecks = 0;
    int     cycleCount  = 0;
    int     cycleLimit  = 0;
    integer seed;
    string  lines [$];

    clockGen #(.HalfPeriod(5), .ResetCycles(16)) uClockGen (
        .loadplat(loadplat),
        .rstN    (rstN)
    );

    playfieldTop #(
        .NumPlatforms(NumPlatforms),
        .LfsrSeed    (LfsrSeed),
        .XOffset     (XOffset),
        .RowPitch    (RowPitch)
    ) uut (
        .loadplat (loadplat),
        .rstN     (rstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .drawX    (drawX),
        .drawY    (drawY),
        .rgb      (rgb),
        .platforms(platforms),
        .platValid(platValid)
    );

    // ------------------------------------------------------------------------
    // model of LFSR stages, registers and platform rows
    // ------------------------------------------------------------------------

    function automatic logic [8:0] seedFor(input int stage);
        logic [17:0] doubled;
        int          r;
        doubled = {LfsrSeed, LfsrSeed};
        r = stage % 9;
        return doubled[17 - r -: 9];
    endfunction

    // taps at bits 9 and 5
    function automatic logic [8:0] nextLfsr(input logic [8:0] state);
        logic feedback;
        feedback = state[8] ^ state[4];
        return (state << 1) | {8'b0, feedback};
    endfunction

    function automatic logic [9:0] modelPlatX(input int i);
        if (edgeCount == 0)
            return '0;
        return 10'(XOffset + int'(prevModel[i]));
    endfunction

    function automatic logic [9:0] modelPlatY(input int i);
        int y;
        if (edgeCount == 0)
            return '0;
        y = RowPitch * (i + 1);
        if (appliedScroll.refreshEn)
            y += int'(appliedScroll.displacement);
        return 10'(y);
    endfunction

    always @(posedge loadplat or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < NumPlatforms; i++)
            begin
                lfsrModel[i] <= seedFor(i);
                prevModel[i] <= '0;
            end
            ballModel     <= '0;
            cannonModel   <= '0;
            scrollModel   <= '0;
            appliedScroll <= '0;
            edgeCount     <= 0;
        end
        else
        begin
            for (int i = 0; i < NumPlatforms; i++)
            begin
                prevModel[i] <= lfsrModel[i];
                lfsrModel[i] <= nextLfsr(lfsrModel[i]);
            end
            edgeCount     <= edgeCount + 1;
            // rows see the scroll register from before this edge
            appliedScroll <= scrollModel;
            if (psel && penable && pwrite)
            begin
                if (paddr == 4'h0)
                    ballModel <= pwdata[29:0];
                else if (paddr == 4'h4)
                    cannonModel <= pwdata[29:0];
                else if (paddr == 4'h8)
                    scrollModel <= pwdata[8:0];
            end
        end
    end

    // every platform, every cycle
    always @(negedge loadplat)
    begin
        if (edgeCount > 0)
        begin
            platChecks++;
            if (platValid !== 1'b1)
            begin
                platErrors++;
                $display("[ERROR] %0t: platValid got %b expected 1", $time, platValid);
            end
            for (int i = 0; i < NumPlatforms; i++)
            begin
                if (platforms[i].x !== modelPlatX(i))
                begin
                    platErrors++;
                    $display("[ERROR] %0t: platforms[%0d].x got %0d expected %0d",
                             $time, i, platforms[i].x, modelPlatX(i));
                end
                if (platforms[i].y !== modelPlatY(i))
                begin
                    platErrors++;
                    $display("[ERROR] %0t: platforms[%0d].y got %0d expected %0d",
                             $time, i, platforms[i].y, modelPlatY(i));
                end
            end
        end
    end

    always @(posedge loadplat)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            $display("timeout: run did not end within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // expected colour
    // ------------------------------------------------------------------------

    function automatic logic inBox(input int px, input int py, input int cx,
                                   input int cy, input int hx, input int hy);
        int dx;
        int dy;
        dx = (px > cx) ? px - cx : cx - px;
        dy = (py > cy) ? py - cy : cy - py;
        return (dx <= hx) && (dy <= hy);
    endfunction

    function automatic logic [23:0] expectedColor(input int px, input int py);
        logic platIn;
        platIn = 1'b0;
        for (int i = 0; i < NumPlatforms; i++)
            platIn |= inBox(px, py, int'(modelPlatX(i)), int'(modelPlatY(i)), HalfX, HalfY);
        if (inBox(px, py, int'(ballModel.x), int'(ballModel.y),
                  int'(ballModel.size), int'(ballModel.size)))
            return BallRgb;
        if (platIn)
            return PlatRgb;
        if (inBox(px, py, int'(cannonModel.x), int'(cannonModel.y),
                  int'(cannonModel.size), int'(cannonModel.size)))
            return CannonRgb;
        return BackRgb;
    endfunction

    // ------------------------------------------------------------------------
    // bus and probe tasks, all start and end on a falling edge
    // ------------------------------------------------------------------------

    function automatic logic isMapped(input logic [3:0] addr);
        return (addr == 4'h0) || (addr == 4'h4) || (addr == 4'h8);
    endfunction

    task automatic apbTransfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err, output logic ready);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge loadplat);
        penable = 1'b1;
        // sampled at the edge that closes the access cycle
        @(posedge loadplat);
        rdata = prdata;
        err   = pslverr;
        ready = pready;
        @(negedge loadplat);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic accessReg(input logic write, input logic [3:0] addr,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic        ready;
        apbTransfer(write, addr, write ? data : 32'h0, rdata, err, ready);
        apbChecks++;
        if (err !== !isMapped(addr))
        begin
            apbErrors++;
            $display("[ERROR] %0t: pslverr got %b expected %b", $time, err, !isMapped(addr));
        end
        if (ready !== 1'b1)
        begin
            apbErrors++;
            $display("[ERROR] %0t: pready got %b expected 1", $time, ready);
        end
        if (!write && rdata !== data)
        begin
            apbErrors++;
            $display("[ERROR] %0t: prdata got %h expected %h", $time, rdata, data);
        end
    endtask

    task automatic probePixel(input int px, input int py);
        logic [23:0] expected;
        drawX = 10'(px);
        drawY = 10'(py);
        expected = expectedColor(px, py);
        @(negedge loadplat);
        pixelChecks++;
        if (rgb !== expected)
        begin
            pixelErrors++;
            $display("[ERROR] %0t: rgb at (%0d,%0d) got %h expected %h",
                     $time, px, py, rgb, expected);
        end
    endtask

    // centre, a corner, one step past it, then a random pixel
    task automatic platformProbes(input int count);
        int idx;
        int r;
        int sx;
        int sy;
        int ox;
        int oy;
        int rx;
        int ry;
        for (int k = 0; k < count; k++)
        begin
            idx = k % NumPlatforms;
            r = $random(seed);
            sx = r[0] ? HalfX : -HalfX;
            sy = r[1] ? HalfY : -HalfY;
            ox = sx;
            oy = sy;
            if (r[2])
                ox = sx + (r[0] ? 1 : -1);
            else
                oy = sy + (r[1] ? 1 : -1);
            // rows move every edge so positions are read per probe
            probePixel(int'(platforms[idx].x), int'(platforms[idx].y));
            probePixel(int'(platforms[idx].x) + sx, int'(platforms[idx].y) + sy);
            probePixel(int'(platforms[idx].x) + ox, int'(platforms[idx].y) + oy);
            rx = $unsigned($random(seed)) % 640;
            ry = $unsigned($random(seed)) % 480;
            probePixel(rx, ry);
        end
    endtask

    task automatic runCommand(input string text);
        byte   op;
        int    n;
        int    a;
        int    b;
        string args;
        op = text.getc(0);
        if (text.len() < 2 || op == "#" || op == 8'h0A || op == 8'h0D)
            return;
        args = text.substr(1, text.len() - 1);
        n = 0;
        case (op)
            "W":     n = $sscanf(args, "%h %h", a, b);
            "R":     n = $sscanf(args, "%h %h", a, b);
            "P":     n = $sscanf(args, "%d %d", a, b);
            "N":     n = 1 + $sscanf(args, "%d", a);
            default: n = 0;
        endcase
        if (n != 2)
        begin
            otherErrors++;
            $display("malformed line in test file: %s", text);
        end
        else if (op == "W" || op == "R")
            accessReg(op == "W", 4'(a), 32'(b));
        else if (op == "P")
            probePixel(a, b);
        else
            platformProbes(a);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial
    begin
        int    fd;
        int    status;
        int    count;
        int    sumN;
        string line;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        drawX   = '0;
        drawY   = '0;
        seed    = 32'hc615_1198;
        sumN    = 0;

        fd = $fopen(TestFile, "r");
        if (fd == 0)
        begin
            otherErrors++;
            $display("could not open the test file %s", TestFile);
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                status = $fgets(line, fd);
                if (status != 0)
                    lines.push_back(line);
            end
            $fclose(fd);
        end

        foreach (lines[i])
        begin
            line = lines[i];
            count = 0;
            if (line.getc(0) == "N")
                status = $sscanf(line.substr(1, line.len() - 1), "%d", count);
            sumN += count;
        end
        cycleLimit = 16 + 4 * lines.size() + 64 * sumN + 200;

        @(posedge rstN);
        if (platValid !== 1'b0)
        begin
            platErrors++;
            $display("[ERROR] %0t: platValid got %b expected 0", $time, platValid);
        end

        foreach (lines[i])
            runCommand(lines[i]);

        $display("checks apb %0d, platform cycles %0d, pixel %0d; errors apb %0d, %s%0d, %s%0d, %s%0d",
                 apbChecks, platChecks, pixelChecks, apbErrors,
                 "platform ", platErrors, "pixel ", pixelErrors, "other ", otherErrors);
        if (apbErrors + platErrors + pixelErrors + otherErrors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/pixelTests.txt */
# W addr data / R addr expected: APB access, hex; pslverr expected when addr is unmapped
# P x y: pixel probe, decimal; N count: platform centre, corner, outside and random probes
W 0 D2C02806
R 0 12C02806
W 4 53603009
R 4 13603009
W 8 FFFFFE40
R 8 00000040
W C 12345678
R C 00000000
R 2 00000000
R 0 12C02806
P 300 10
P 306 16
P 294 4
P 307 10
P 300 17
P 315 12
P 319 21
P 320 21
P 310 22
P 293 10
N 32
W 8 00000019
R 8 00000019
N 16
W 0 1684B03C
W 4 0C825864
R 4 0C825864
N 32
P 360 300
P 200 150

/* src.f */
common/videoPkg.sv
common/playfieldPkg.sv
logic/apbRegs.sv
playfield/lfsrChain.sv
playfield/platformBank.sv
logic/colorMapper.sv
logic/playfieldTop.sv
sim/clockGen.sv
sim/playfieldTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module playfieldTb --Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
